//--- sources.f
common/ahbPkg.sv
ahbMaster/burstCtrl.sv
ahbMaster/addrGen.sv
ahbMaster/dataPhase.sv
ahbMaster/ahbMaster.sv
verification/ahbMasterProtocol_chk.sv
verification/ahbMasterTb.sv

//--- Bender.yml
package:
  name: ahb_master

sources:
  - common/ahbPkg.sv
  - ahbMaster/burstCtrl.sv
  - ahbMaster/addrGen.sv
  - ahbMaster/dataPhase.sv
  - ahbMaster/ahbMaster.sv
  - target: simulation
    files:
      - verification/ahbMasterProtocol_chk.sv
      - verification/ahbMasterTb.sv

//--- verification/ahbMasterTb.sv
`timescale 1ns/1ps
`default_nettype none

module ahbMasterTb
        import ahbPkg::*;
();

        localparam int numCmds = 60;
        localparam int maxCycles = numCmds * (16 * 4 + 10);
        localparam addrT blockBase = 32'h0000_1400;    // One 1 KB block

        logic Hclk;
        logic rstN;
        logic cmdStart;
        logic cmdWrite;
        sizeT cmdSize;
        burstT cmdBurst;
        addrT cmdAddr;
        logic hReady;
        dataT hRdata;
        logic busy;
        addrT hAddr;
        transT hTrans;
        logic hWrite;
        sizeT hSize;
        burstT hBurst;
        dataT hWdata;
        dataT rdData;
        logic rdValid;

        dataT mem [0:255];
        dataT modelMem [0:255];
        addrT expAddrQ [$];
        dataT expRdQ [$];
        dataT expWdQ [$];
        dataT lfsrModel;
        logic expWrite;
        sizeT expSize;
        burstT expBurst;
        int beatsSeen;
        int cycles;
        logic slvPending;
        logic slvWrite;
        addrT slvAddr;
        sizeT slvSize;

        assign hRdata = mem[slvAddr[9:2]];

        ahbMaster #(
                .lfsrSeed(32'h1)
        ) dut_i (
                .Hclk(Hclk),
                .rstN(rstN),
                .cmdStart(cmdStart),
                .cmdWrite(cmdWrite),
                .cmdSize(cmdSize),
                .cmdBurst(cmdBurst),
                .cmdAddr(cmdAddr),
                .hReady(hReady),
                .hRdata(hRdata),
                .busy(busy),
                .hAddr(hAddr),
                .hTrans(hTrans),
                .hWrite(hWrite),
                .hSize(hSize),
                .hBurst(hBurst),
                .hWdata(hWdata),
                .rdData(rdData),
                .rdValid(rdValid)
        );

        initial begin
                Hclk = 1'b0;
                forever #50 Hclk = ~Hclk;
        end

        function automatic int beatsFor(input burstT burst);
                case (burst)
                        burstWrap4, burstIncr4: return 4;
                        burstWrap8, burstIncr8: return 8;
                        burstWrap16, burstIncr16: return 16;
                        default: return 1;    // SINGLE and undefined INCR
                endcase
        endfunction

        function automatic addrT stepAddress(input addrT addr, input sizeT size, input burstT burst);
                addrT width;
                addrT span;
                addrT base;
                width = 32'd1 << size;
                if (burst == burstWrap4 || burst == burstWrap8 || burst == burstWrap16) begin
                        span = width * beatsFor(burst);
                        base = addr - (addr % span);
                        return base + ((addr - base + width) % span);    // Stay in aligned block
                end
                return addr + width;
        endfunction

        function automatic dataT mergeLanes(input dataT old, input dataT wdata, input addrT addr,
                        input sizeT size);
                dataT result;
                int lane;
                result = old;
                for (lane = 0; lane < 4; lane++) begin
                        if ((lane >> size) == (addr[1:0] >> size)) begin
                                result[8 * lane +: 8] = wdata[8 * lane +: 8];
                        end
                end
                return result;
        endfunction

        function automatic dataT lfsrStep(input dataT value);
                return value[0] ? ((value >> 1) ^ lfsrPoly) : (value >> 1);
        endfunction

        task automatic compareValue(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
                if (actual !== expected) begin
                        $display("FAIL %s expected %h actual %h", name, expected, actual);
                        $display("** FAIL **");
                        $fatal(1, "Value mismatch on %s", name);
                end
        endtask

        task automatic abortRun(input string reason);
                $display("%s", reason);
                $display("** FAIL **");
                $fatal(1, "Run aborted");
        endtask

        task automatic driveReady();
                forever begin
                        @(negedge Hclk);
                        hReady = ($urandom % 3) != 0;    // Wait state about a third of the time
                end
        endtask

        task automatic issueCommand();
                sizeT size;
                burstT burst;
                logic write;
                int beats;
                int k;
                addrT span;
                addrT addr;
                addrT beatAddr;
                size = sizeT'($urandom % 3);
                burst = burstT'($urandom % 8);
                write = $urandom % 2;
                beats = beatsFor(burst);
                span = (32'd1 << size) * beats;
                addr = blockBase + (($urandom % (1025 - span)) & ~((32'd1 << size) - 32'd1));
                expWrite = write;
                expSize = size;
                expBurst = (burst == burstIncr) ? burstSingle : burst;
                beatsSeen = 0;
                expAddrQ.push_back(addr);
                for (k = 1; k < beats; k++) begin
                        expAddrQ.push_back(stepAddress(expAddrQ[k - 1], size, burst));
                end
                for (k = 0; k < beats; k++) begin
                        beatAddr = expAddrQ[k];
                        if (write) begin
                                expWdQ.push_back(lfsrModel);
                                modelMem[beatAddr[9:2]] = mergeLanes(modelMem[beatAddr[9:2]],
                                        lfsrModel, beatAddr, size);
                                lfsrModel = lfsrStep(lfsrModel);
                        end else begin
                                expRdQ.push_back(modelMem[beatAddr[9:2]]);
                        end
                end
                @(negedge Hclk);
                cmdStart = 1'b1;
                cmdWrite = write;
                cmdSize = size;
                cmdBurst = burst;
                cmdAddr = addr;
                @(negedge Hclk);
                cmdStart = 1'b0;
                compareValue("busy", 32'd1, busy);
                if ($urandom % 2) begin    // Stray strobe that must be ignored
                        cmdStart = 1'b1;
                        cmdWrite = ~write;
                        cmdBurst = burstT'($urandom % 8);
                        cmdAddr = blockBase + ($urandom % 256) * 4;
                        @(negedge Hclk);
                        cmdStart = 1'b0;
                end
                while (busy) @(negedge Hclk);
                compareValue("beats", beats, beatsSeen);
                @(negedge Hclk);
                compareValue("addrQueue", 32'd0, expAddrQ.size());
                compareValue("rdQueue", 32'd0, expRdQ.size());
                compareValue("wdQueue", 32'd0, expWdQ.size());
        endtask

        // Slave memory and bus checks
        always @(posedge Hclk) begin
                if (rstN) begin
                        if (rdValid) begin
                                if (expRdQ.size() == 0) begin
                                        abortRun("rdValid pulsed with no read outstanding");
                                end else begin
                                        compareValue("rdData", expRdQ.pop_front(), rdData);
                                end
                        end
                        if (slvPending && hReady && slvWrite) begin
                                if (expWdQ.size() == 0) begin
                                        abortRun("Write data phase seen with no write outstanding");
                                end else begin
                                        compareValue("hWdata", expWdQ.pop_front(), hWdata);
                                end
                                mem[slvAddr[9:2]] <= mergeLanes(mem[slvAddr[9:2]], hWdata,
                                        slvAddr, slvSize);
                        end
                        if (hReady) begin
                                if (hTrans != transIdle) begin
                                        if (expAddrQ.size() == 0) begin
                                                abortRun("Address phase seen with no beat expected");
                                        end else begin
                                                compareValue("hAddr", expAddrQ.pop_front(), hAddr);
                                                compareValue("hTrans",
                                                        (beatsSeen == 0) ? transNonseq : transSeq,
                                                        hTrans);
                                                compareValue("hWrite", expWrite, hWrite);
                                                compareValue("hSize", expSize, hSize);
                                                compareValue("hBurst", expBurst, hBurst);
                                                beatsSeen++;
                                        end
                                end
                                slvPending <= (hTrans != transIdle);
                                slvAddr <= hAddr;
                                slvWrite <= hWrite;
                                slvSize <= hSize;
                        end
                end
        end

        always @(negedge Hclk) begin
                if (dut_i.burstCtrl_i.protocolChk_i.failCount != 0) begin
                        abortRun("A bus protocol assertion in burstCtrl failed");
                end
        end

        always @(posedge Hclk) begin
                cycles <= cycles + 1;
                if (cycles >= maxCycles) begin
                        $display("Timeout after %0d cycles, the commands did not complete", cycles);
                        $display("** FAIL **");
                        $fatal(1, "Timeout");
                end
        end

        initial begin
                int n;
                int i;
                void'($urandom(32'h2609_86de));
                cycles = 0;
                rstN = 1'b0;
                cmdStart = 1'b0;
                cmdWrite = 1'b0;
                cmdSize = sizeByte;
                cmdBurst = burstSingle;
                cmdAddr = '0;
                hReady = 1'b1;
                lfsrModel = 32'h1;
                expWrite = 1'b0;
                expSize = sizeByte;
                expBurst = burstSingle;
                beatsSeen = 0;
                slvPending = 1'b0;
                slvWrite = 1'b0;
                slvAddr = '0;
                slvSize = sizeByte;
                for (i = 0; i < 256; i++) begin
                        mem[i] = (dataT'(i) * 32'h0101_0101) ^ 32'h00ff_00ff;
                        modelMem[i] = (dataT'(i) * 32'h0101_0101) ^ 32'h00ff_00ff;
                end
                repeat (8) @(negedge Hclk);
                rstN = 1'b1;
                compareValue("hTrans", transIdle, hTrans);
                compareValue("busy", 32'd0, busy);
                compareValue("rdValid", 32'd0, rdValid);
                fork
                        driveReady();
                join_none
                for (n = 0; n < numCmds; n++) begin
                        issueCommand();
                end
                for (i = 0; i < 256; i++) begin
                        compareValue("mem", modelMem[i], mem[i]);
                end
                if (dut_i.burstCtrl_i.protocolChk_i.failCount != 0) begin
                        abortRun("A bus protocol assertion in burstCtrl failed");
                end else begin
                        $display("** PASS **");
                        $finish;
                end
        end

endmodule

`default_nettype wire

//--- verification/ahbMasterProtocol_chk.sv
`timescale 1ns/1ps
`default_nettype none

module ahbMasterProtocolChk import ahbPkg::*; (
        input wire logic Hclk,
        input wire logic rstN,
        input wire logic hReady,
        input wire logic busy,
        input wire logic load,
        input wire transT hTrans,
        input wire logic hWrite
);

        int failCount = 0;

        stableUnderWait: assert property (@(posedge Hclk) disable iff (!rstN)
                (hTrans != transIdle && !hReady) |=> ($stable(hTrans) && $stable(hWrite)))
                else begin
                        $error("hTrans or hWrite changed while hReady was low");
                        failCount++;
                end

        idleWhenFree: assert property (@(posedge Hclk) disable iff (!rstN)
                !busy |-> (hTrans == transIdle))
                else begin
                        $error("hTrans not idle while busy is low");
                        failCount++;
                end

        // Burst always opens with NONSEQ
        firstBeatNonseq: assert property (@(posedge Hclk) disable iff (!rstN)
                load |=> (hTrans == transNonseq))
                else begin
                        $error("First beat of a burst is not NONSEQ");
                        failCount++;
                end

endmodule

bind burstCtrl ahbMasterProtocolChk protocolChk_i (
        .Hclk(Hclk),
        .rstN(rstN),
        .hReady(hReady),
        .busy(busy),
        .load(load),
        .hTrans(hTrans),
        .hWrite(hWrite)
);

`default_nettype wire

//--- ahbMaster/ahbMaster.sv
`timescale 1ns/1ps
`default_nettype none

module ahbMaster import ahbPkg::*; #(
        parameter dataT lfsrSeed = 32'h1
) (
        input wire logic Hclk,
        input wire logic rstN,
        input wire logic cmdStart,
        input wire logic cmdWrite,
        input wire sizeT cmdSize,
        input wire burstT cmdBurst,
        input wire addrT cmdAddr,
        input wire logic hReady,
        input wire dataT hRdata,
        output logic busy,
        output addrT hAddr,
        output transT hTrans,
        output logic hWrite,
        output sizeT hSize,
        output burstT hBurst,
        output dataT hWdata,
        output dataT rdData,
        output logic rdValid
);

        logic load;
        logic beatAccept;
        logic dataPending;

        burstCtrl burstCtrl_i (
                .Hclk(Hclk),
                .rstN(rstN),
                .cmdStart(cmdStart),
                .cmdWrite(cmdWrite),
                .cmdBurst(cmdBurst),
                .hReady(hReady),
                .dataPending(dataPending),
                .busy(busy),
                .hTrans(hTrans),
                .hWrite(hWrite),
                .load(load),
                .beatAccept(beatAccept)
        );

        addrGen addrGen_i (
                .Hclk(Hclk),
                .rstN(rstN),
                .load(load),
                .beatAccept(beatAccept),
                .cmdAddr(cmdAddr),
                .cmdSize(cmdSize),
                .cmdBurst(cmdBurst),
                .hAddr(hAddr),
                .hSize(hSize),
                .hBurst(hBurst)
        );

        dataPhase #(
                .lfsrSeed(lfsrSeed)
        ) dataPhase_i (
                .Hclk(Hclk),
                .rstN(rstN),
                .hReady(hReady),
                .beatAccept(beatAccept),
                .hWrite(hWrite),
                .hRdata(hRdata),
                .hWdata(hWdata),
                .rdData(rdData),
                .rdValid(rdValid),
                .dataPending(dataPending)
        );

endmodule

`default_nettype wire

//--- ahbMaster/dataPhase.sv
`timescale 1ns/1ps
`default_nettype none

module dataPhase import ahbPkg::*; #(
        parameter dataT lfsrSeed = 32'h1
) (
        input wire logic Hclk,
        input wire logic rstN,
        input wire logic hReady,
        input wire logic beatAccept,
        input wire logic hWrite,
        input wire dataT hRdata,
        output dataT hWdata,
        output dataT rdData,
        output logic rdValid,
        output logic dataPending
);

        logic pendWrite;
        logic phaseDone;
        dataT lfsr;
        dataT lfsrNext;

        assign phaseDone = dataPending && hReady;
        assign hWdata = lfsr;    // Held until the write phase completes
        assign lfsrNext = lfsr[0] ? ((lfsr >> 1) ^ lfsrPoly) : (lfsr >> 1);

        // One beat in flight, overlapping the next address phase
        always_ff @(posedge Hclk or negedge rstN) begin
                if (!rstN) begin
                        dataPending <= 1'b0;
                        pendWrite <= 1'b0;
                        rdValid <= 1'b0;
                        lfsr <= lfsrSeed;
                end else begin
                        if (hReady) begin
                                dataPending <= beatAccept;
                                if (beatAccept) begin
                                        pendWrite <= hWrite;
                                end
                        end
                        if (phaseDone && pendWrite) begin
                                lfsr <= lfsrNext;
                        end
                        rdValid <= phaseDone && !pendWrite;
                end
        end

        always_ff @(posedge Hclk) begin
                if (phaseDone && !pendWrite) begin
                        rdData <= hRdata;
                end
        end

endmodule

`default_nettype wire

//--- ahbMaster/addrGen.sv
`timescale 1ns/1ps
`default_nettype none

module addrGen import ahbPkg::*; (
        input wire logic Hclk,
        input wire logic rstN,
        input wire logic load,
        input wire logic beatAccept,
        input wire addrT cmdAddr,
        input wire sizeT cmdSize,
        input wire burstT cmdBurst,
        output addrT hAddr,
        output sizeT hSize,
        output burstT hBurst
);

        addrT stepBytes;
        addrT wrapMask;
        addrT incAddr;
        addrT nextAddr;

        always_comb begin
                case (hSize)
                        sizeByte: stepBytes = 32'd1;
                        sizeHalf: stepBytes = 32'd2;
                        default: stepBytes = 32'd4;
                endcase
                // Low bits that cycle inside the wrap block
                case (hBurst)
                        burstWrap4: wrapMask = (stepBytes << 2) - 32'd1;
                        burstWrap8: wrapMask = (stepBytes << 3) - 32'd1;
                        burstWrap16: wrapMask = (stepBytes << 4) - 32'd1;
                        default: wrapMask = '1;    // Plain increment
                endcase
                incAddr = hAddr + stepBytes;
                nextAddr = (hAddr & ~wrapMask) | (incAddr & wrapMask);
        end

        always_ff @(posedge Hclk or negedge rstN) begin
                if (!rstN) begin
                        hAddr <= '0;
                        hSize <= sizeByte;
                        hBurst <= burstSingle;
                end else if (load) begin
                        hAddr <= cmdAddr;
                        hSize <= (cmdSize > sizeWord) ? sizeWord : cmdSize;
                        hBurst <= (cmdBurst == burstIncr) ? burstSingle : cmdBurst;
                end else if (beatAccept) begin
                        hAddr <= nextAddr;
                end
        end

endmodule

`default_nettype wire

//--- ahbMaster/burstCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module burstCtrl import ahbPkg::*; (
        input wire logic Hclk,
        input wire logic rstN,
        input wire logic cmdStart,
        input wire logic cmdWrite,
        input wire burstT cmdBurst,
        input wire logic hReady,
        input wire logic dataPending,
        output logic busy,
        output transT hTrans,
        output logic hWrite,
        output logic load,
        output logic beatAccept
);

        typedef enum logic [1:0] {
                stIdle,
                stFirst,
                stNext,
                stDrain
        } stateT;

        stateT state;
        beatCntT beatsLeft;

        function automatic beatCntT lastBeat(input burstT burst);
                case (burst)
                        burstSingle, burstIncr: lastBeat = 4'd0;
                        burstWrap4, burstIncr4: lastBeat = 4'd3;
                        burstWrap8, burstIncr8: lastBeat = 4'd7;
                        burstWrap16, burstIncr16: lastBeat = 4'd15;
                        default: lastBeat = 4'd0;
                endcase
        endfunction

        assign load = cmdStart && (state == stIdle);    // Strobe ignored while busy
        assign busy = (state != stIdle);
        assign beatAccept = hReady && ((state == stFirst) || (state == stNext));

        always_comb begin
                case (state)
                        stFirst: hTrans = transNonseq;
                        stNext: hTrans = transSeq;
                        default: hTrans = transIdle;
                endcase
        end

        always_ff @(posedge Hclk or negedge rstN) begin
                if (!rstN) begin
                        state <= stIdle;
                        beatsLeft <= '0;
                        hWrite <= 1'b0;
                end else begin
                        case (state)
                                stIdle: begin
                                        if (load) begin
                                                hWrite <= cmdWrite;
                                                beatsLeft <= lastBeat(cmdBurst);
                                                state <= stFirst;
                                        end
                                end
                                stFirst, stNext: begin
                                        if (beatAccept) begin
                                                if (beatsLeft == '0) begin
                                                        state <= stDrain;    // Last address accepted
                                                end else begin
                                                        beatsLeft <= beatsLeft - 1'b1;
                                                        state <= stNext;
                                                end
                                        end
                                end
                                stDrain: begin
                                        // Last data phase completes on this edge
                                        if (hReady || !dataPending) begin
                                                state <= stIdle;
                                        end
                                end
                                default: state <= stIdle;
                        endcase
                end
        end

endmodule

`default_nettype wire

//--- common/ahbPkg.sv
`default_nettype none

package ahbPkg;

        typedef logic [31:0] addrT;
        typedef logic [31:0] dataT;
        typedef logic [1:0] transT;
        typedef logic [2:0] burstT;
        typedef logic [2:0] sizeT;
        typedef logic [3:0] beatCntT;    // Remaining beats minus one

        localparam transT transIdle = 2'b00;
        localparam transT transNonseq = 2'b10;
        localparam transT transSeq = 2'b11;

        localparam burstT burstSingle = 3'd0;
        localparam burstT burstIncr = 3'd1;    // Undefined length is issued as SINGLE
        localparam burstT burstWrap4 = 3'd2;
        localparam burstT burstIncr4 = 3'd3;
        localparam burstT burstWrap8 = 3'd4;
        localparam burstT burstIncr8 = 3'd5;
        localparam burstT burstWrap16 = 3'd6;
        localparam burstT burstIncr16 = 3'd7;

        localparam sizeT sizeByte = 3'd0;
        localparam sizeT sizeHalf = 3'd1;
        localparam sizeT sizeWord = 3'd2;

        // Right-shifting Galois LFSR feedback taps for write data
        localparam dataT lfsrPoly = 32'h8020_0003;

endpackage

`default_nettype wire
